// File: rtl/ooo_pkg.sv
// Core sizes, index and data types, ALU operation encoding
package ooo_pkg;

    // --------------------------------------------------
    // Sizes
    // --------------------------------------------------
    // Data path width
    localparam int XLEN      = 32;
    // Architectural registers seen by software
    localparam int ARCH_REGS = 8;
    // Physical registers behind the rename map
    localparam int PHYS_REGS = 16;
    // Reorder buffer slots
    localparam int ROB_DEPTH = 8;

    // --------------------------------------------------
    // Index and data types
    // --------------------------------------------------
    typedef logic [$clog2(ARCH_REGS)-1:0] arch_reg_t;
    typedef logic [$clog2(PHYS_REGS)-1:0] phys_reg_t;
    // Wraps naturally, depth is a power of two
    typedef logic [$clog2(ROB_DEPTH)-1:0] rob_idx_t;
    typedef logic [XLEN-1:0]              data_t;

    // --------------------------------------------------
    // Operations
    // --------------------------------------------------
    // LI ignores both sources and writes the immediate
    typedef enum logic [2:0] {
        OP_LI  = 3'd0,
        OP_ADD = 3'd1,
        OP_SUB = 3'd2,
        OP_AND = 3'd3,
        OP_XOR = 3'd4
    } op_e;

endpackage

// File: rtl/ooo_if.sv
// Dispatch, issue and common data bus interfaces with their modports
interface dispatch_if;
    import ooo_pkg::*;

    // Renamed instruction, one per cycle
    logic      valid;
    op_e       op;
    data_t     imm;
    phys_reg_t prs1;
    logic      rs1_ready;
    phys_reg_t prs2;
    logic      rs2_ready;
    phys_reg_t prd;
    phys_reg_t old_prd;
    arch_reg_t rd;
    // Back from ROB and RS
    rob_idx_t  rob_tail;
    logic      rob_full;
    logic      rs_full;

    modport rename (
        output valid, op, imm, prs1, rs1_ready, prs2, rs2_ready, prd, old_prd, rd,
        input  rob_full, rs_full
    );
    modport station (
        input  valid, op, imm, prs1, rs1_ready, prs2, rs2_ready, prd, rob_tail,
        output rs_full
    );
    modport rob (
        input  valid, rd, old_prd,
        output rob_tail, rob_full
    );
endinterface

interface issue_if;
    import ooo_pkg::*;

    logic      valid;
    op_e       op;
    data_t     imm;
    phys_reg_t prs1;
    phys_reg_t prs2;
    phys_reg_t prd;
    rob_idx_t  rob_idx;

    modport source (output valid, op, imm, prs1, prs2, prd, rob_idx);
    modport sink   (input  valid, op, imm, prs1, prs2, prd, rob_idx);
endinterface

interface cdb_if;
    import ooo_pkg::*;

    logic      valid;
    phys_reg_t prd;
    rob_idx_t  rob_idx;
    data_t     data;

    modport source (output valid, prd, rob_idx, data);
    modport sink   (input  valid, prd, rob_idx, data);
endinterface

// File: rtl/rename_unit.sv
// Map table, free list FIFO, busy table and dispatch stall logic
module rename_unit (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                inst_valid_i,
    input  ooo_pkg::op_e        inst_op_i,
    input  ooo_pkg::arch_reg_t  inst_rd_i,
    input  ooo_pkg::arch_reg_t  inst_rs1_i,
    input  ooo_pkg::arch_reg_t  inst_rs2_i,
    input  ooo_pkg::data_t      inst_imm_i,
    input  logic                free_valid_i,
    input  ooo_pkg::phys_reg_t  free_prd_i,
    output logic                inst_ready_o,
    dispatch_if.rename          dp,
    cdb_if.sink                 cdb
);
    import ooo_pkg::*;

    // Spare registers beyond the architectural set
    localparam int FL_DEPTH = PHYS_REGS - ARCH_REGS;
    localparam int FL_CNT_W = $clog2(FL_DEPTH + 1);

    typedef logic [$clog2(FL_DEPTH)-1:0] fl_ptr_t;

    phys_reg_t             map_q [ARCH_REGS];
    phys_reg_t             fl_q  [FL_DEPTH];
    fl_ptr_t               fl_head_q;
    fl_ptr_t               fl_tail_q;
    logic [FL_CNT_W-1:0]   fl_count_q;
    logic [PHYS_REGS-1:0]  busy_q;

    logic      accept;
    phys_reg_t prs1;
    phys_reg_t prs2;
    phys_reg_t new_prd;
    logic      rs1_hit;
    logic      rs2_hit;

    // --------------------------------------------------
    // Lookup and stall
    // --------------------------------------------------
    assign inst_ready_o = (fl_count_q != '0) && !dp.rob_full && !dp.rs_full;
    assign accept       = inst_valid_i && inst_ready_o;

    assign prs1    = map_q[inst_rs1_i];
    assign prs2    = map_q[inst_rs2_i];
    assign new_prd = fl_q[fl_head_q];

    // Producer broadcasting right now counts as done
    assign rs1_hit = !busy_q[prs1] || (cdb.valid && cdb.prd == prs1);
    assign rs2_hit = !busy_q[prs2] || (cdb.valid && cdb.prd == prs2);

    // Dispatch bundle
    assign dp.valid     = accept;
    assign dp.op        = inst_op_i;
    assign dp.imm       = inst_imm_i;
    assign dp.prs1      = prs1;
    assign dp.prs2      = prs2;
    // LI has no real sources
    assign dp.rs1_ready = (inst_op_i == OP_LI) || rs1_hit;
    assign dp.rs2_ready = (inst_op_i == OP_LI) || rs2_hit;
    assign dp.prd       = new_prd;
    assign dp.old_prd   = map_q[inst_rd_i];
    assign dp.rd        = inst_rd_i;

    // --------------------------------------------------
    // State update
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            // Identity map, upper half free
            for (int i = 0; i < ARCH_REGS; i++) begin
                map_q[i] <= phys_reg_t'(i);
            end
            for (int i = 0; i < FL_DEPTH; i++) begin
                fl_q[i] <= phys_reg_t'(ARCH_REGS + i);
            end
            fl_head_q  <= '0;
            fl_tail_q  <= '0;
            fl_count_q <= FL_CNT_W'(FL_DEPTH);
            busy_q     <= '0;
        end else begin
            if (accept) begin
                map_q[inst_rd_i] <= new_prd;
                fl_head_q        <= fl_head_q + 1'b1;
            end
            // Retired old mapping back to the tail
            if (free_valid_i) begin
                fl_q[fl_tail_q] <= free_prd_i;
                fl_tail_q       <= fl_tail_q + 1'b1;
            end
            fl_count_q <= fl_count_q + FL_CNT_W'(free_valid_i) - FL_CNT_W'(accept);
            // Clear before set, a fresh tag is never on the bus
            if (cdb.valid) begin
                busy_q[cdb.prd] <= 1'b0;
            end
            if (accept) begin
                busy_q[new_prd] <= 1'b1;
            end
        end
    end

    // Popped register must be free and no longer pending
    a_fl_pop: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        accept |-> !busy_q[new_prd]);

endmodule

// File: rtl/reservation_station.sv
// Reservation station with CDB wakeup and oldest-ready issue
module reservation_station #(
    parameter int RS_DEPTH = 4
) (
    input  logic        clk_i,
    input  logic        rst_n_i,
    dispatch_if.station dp,
    cdb_if.sink         cdb,
    issue_if.source     iss
);
    import ooo_pkg::*;

    localparam int IDX_W = $clog2(RS_DEPTH);

    typedef logic [IDX_W-1:0] idx_t;

    // Entry storage
    logic [RS_DEPTH-1:0] ent_valid_q;
    op_e                 op_q      [RS_DEPTH];
    data_t               imm_q     [RS_DEPTH];
    phys_reg_t           prs1_q    [RS_DEPTH];
    phys_reg_t           prs2_q    [RS_DEPTH];
    logic                rdy1_q    [RS_DEPTH];
    logic                rdy2_q    [RS_DEPTH];
    phys_reg_t           prd_q     [RS_DEPTH];
    rob_idx_t            rob_idx_q [RS_DEPTH];
    // Count of younger valid entries
    idx_t                age_q     [RS_DEPTH];

    logic iss_found;
    idx_t iss_sel;
    idx_t ins_sel;

    assign dp.rs_full = &ent_valid_q;

    // --------------------------------------------------
    // Oldest ready entry and first free slot
    // --------------------------------------------------
    always_comb begin
        iss_found = 1'b0;
        iss_sel   = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (ent_valid_q[i] && rdy1_q[i] && rdy2_q[i]) begin
                if (!iss_found || age_q[i] > age_q[iss_sel]) begin
                    iss_found = 1'b1;
                    iss_sel   = idx_t'(i);
                end
            end
        end
    end

    always_comb begin
        ins_sel = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (!ent_valid_q[i]) begin
                ins_sel = idx_t'(i);
            end
        end
    end

    assign iss.valid   = iss_found;
    assign iss.op      = op_q[iss_sel];
    assign iss.imm     = imm_q[iss_sel];
    assign iss.prs1    = prs1_q[iss_sel];
    assign iss.prs2    = prs2_q[iss_sel];
    assign iss.prd     = prd_q[iss_sel];
    assign iss.rob_idx = rob_idx_q[iss_sel];

    // --------------------------------------------------
    // Entry update
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            // Wakeup on tag match
            if (cdb.valid && cdb.prd == prs1_q[i]) begin
                rdy1_q[i] <= 1'b1;
            end
            if (cdb.valid && cdb.prd == prs2_q[i]) begin
                rdy2_q[i] <= 1'b1;
            end
            // Older than the issued one loses a younger entry
            age_q[i] <= age_q[i] + idx_t'(dp.valid)
                      - idx_t'(iss_found && age_q[i] > age_q[iss_sel]);
        end
        if (dp.valid) begin
            op_q[ins_sel]      <= dp.op;
            imm_q[ins_sel]     <= dp.imm;
            prs1_q[ins_sel]    <= dp.prs1;
            prs2_q[ins_sel]    <= dp.prs2;
            rdy1_q[ins_sel]    <= dp.rs1_ready;
            rdy2_q[ins_sel]    <= dp.rs2_ready;
            prd_q[ins_sel]     <= dp.prd;
            rob_idx_q[ins_sel] <= dp.rob_tail;
            age_q[ins_sel]     <= '0;
        end
        if (!rst_n_i) begin
            ent_valid_q <= '0;
        end else begin
            if (iss_found) begin
                ent_valid_q[iss_sel] <= 1'b0;
            end
            if (dp.valid) begin
                ent_valid_q[ins_sel] <= 1'b1;
            end
        end
    end

    // Insert slot must be empty
    a_no_write_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        dp.valid |-> !ent_valid_q[ins_sel]);

endmodule

// File: rtl/execute_unit.sv
// Physical register file, single-cycle ALU and registered CDB driver
module execute_unit (
    input  logic    clk_i,
    input  logic    rst_n_i,
    issue_if.sink   iss,
    cdb_if.source   cdb
);
    import ooo_pkg::*;

    data_t                rf_q [PHYS_REGS];
    data_t                opa;
    data_t                opb;
    data_t                alu_res;
    // Broadcast stage
    logic                 cdb_valid_q;
    phys_reg_t            cdb_prd_q;
    rob_idx_t             cdb_rob_q;
    data_t                cdb_data_q;
    // Shadow flag, register holds its current producer's result
    logic [PHYS_REGS-1:0] written_q;

    // Operand read in the issue cycle
    assign opa = rf_q[iss.prs1];
    assign opb = rf_q[iss.prs2];

    always_comb begin
        unique case (iss.op)
            OP_LI:   alu_res = iss.imm;
            OP_ADD:  alu_res = opa + opb;
            OP_SUB:  alu_res = opa - opb;
            OP_AND:  alu_res = opa & opb;
            OP_XOR:  alu_res = opa ^ opb;
            default: alu_res = '0;
        endcase
    end

    assign cdb.valid   = cdb_valid_q;
    assign cdb.prd     = cdb_prd_q;
    assign cdb.rob_idx = cdb_rob_q;
    assign cdb.data    = cdb_data_q;

    // --------------------------------------------------
    // Result register and writeback
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        cdb_prd_q  <= iss.prd;
        cdb_rob_q  <= iss.rob_idx;
        cdb_data_q <= alu_res;
        if (!rst_n_i) begin
            cdb_valid_q <= 1'b0;
            for (int i = 0; i < PHYS_REGS; i++) begin
                rf_q[i]      <= '0;
                written_q[i] <= (i < ARCH_REGS);
            end
        end else begin
            cdb_valid_q <= iss.valid;
            // Write lands as the bus cycle ends
            if (cdb_valid_q) begin
                rf_q[cdb_prd_q]      <= cdb_data_q;
                written_q[cdb_prd_q] <= 1'b1;
            end
            // Pending again once a new producer issues
            if (iss.valid) begin
                written_q[iss.prd] <= 1'b0;
            end
        end
    end

    // ALU sources were written back before the read
    a_src_written: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (iss.valid && iss.op != OP_LI) |-> (written_q[iss.prs1] && written_q[iss.prs2]));

endmodule

// File: rtl/reorder_buffer.sv
// Reorder buffer with CDB completion and in-order retirement
module reorder_buffer (
    input  logic                clk_i,
    input  logic                rst_n_i,
    output logic                free_valid_o,
    output ooo_pkg::phys_reg_t  free_prd_o,
    output logic                rt_valid_o,
    output ooo_pkg::arch_reg_t  rt_rd_o,
    output ooo_pkg::data_t      rt_data_o,
    dispatch_if.rob             dp,
    cdb_if.sink                 cdb
);
    import ooo_pkg::*;

    localparam int CNT_W = $clog2(ROB_DEPTH + 1);

    typedef logic [CNT_W-1:0] cnt_t;

    // Pointers and occupancy
    rob_idx_t             head_q;
    rob_idx_t             tail_q;
    cnt_t                 count_q;
    logic [ROB_DEPTH-1:0] done_q;
    // Slot payload
    arch_reg_t            rd_q      [ROB_DEPTH];
    phys_reg_t            old_prd_q [ROB_DEPTH];
    data_t                data_q    [ROB_DEPTH];

    logic retire;

    assign dp.rob_full = (count_q == cnt_t'(ROB_DEPTH));
    assign dp.rob_tail = tail_q;

    // --------------------------------------------------
    // Retirement from the head
    // --------------------------------------------------
    assign retire       = (count_q != '0) && done_q[head_q];
    assign rt_valid_o   = retire;
    assign rt_rd_o      = rd_q[head_q];
    assign rt_data_o    = data_q[head_q];
    // Previous mapping of rd is dead now
    assign free_valid_o = retire;
    assign free_prd_o   = old_prd_q[head_q];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            done_q  <= '0;
        end else begin
            if (dp.valid) begin
                done_q[tail_q] <= 1'b0;
                tail_q         <= tail_q + 1'b1;
            end
            if (cdb.valid) begin
                done_q[cdb.rob_idx] <= 1'b1;
            end
            if (retire) begin
                done_q[head_q] <= 1'b0;
                head_q         <= head_q + 1'b1;
            end
            count_q <= count_q + cnt_t'(dp.valid) - cnt_t'(retire);
        end
    end

    // Payload capture
    always_ff @(posedge clk_i) begin
        if (dp.valid) begin
            rd_q[tail_q]      <= dp.rd;
            old_prd_q[tail_q] <= dp.old_prd;
        end
        if (cdb.valid) begin
            data_q[cdb.rob_idx] <= cdb.data;
        end
    end

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------
    // Occupancy stays within depth and agrees with the pointers
    a_no_alloc_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (count_q <= cnt_t'(ROB_DEPTH))
        && (rob_idx_t'(tail_q - head_q) == rob_idx_t'(count_q)));

    // Completing slot lies between head and tail and is still pending
    a_complete_live: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        cdb.valid |-> (cnt_t'(rob_idx_t'(cdb.rob_idx - head_q)) < count_q)
                      && !done_q[cdb.rob_idx]);

endmodule

// File: rtl/ooo_core.sv
// Out-of-order core top level with rename, RS, execute and ROB
module ooo_core #(
    parameter int RS_DEPTH = 4
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    // Instruction input
    input  logic                inst_valid_i,
    input  ooo_pkg::op_e        inst_op_i,
    input  ooo_pkg::arch_reg_t  inst_rd_i,
    input  ooo_pkg::arch_reg_t  inst_rs1_i,
    input  ooo_pkg::arch_reg_t  inst_rs2_i,
    input  ooo_pkg::data_t      inst_imm_i,
    output logic                inst_ready_o,
    // Retire stream
    output logic                rt_valid_o,
    output ooo_pkg::arch_reg_t  rt_rd_o,
    output ooo_pkg::data_t      rt_data_o
);
    import ooo_pkg::*;

    // --------------------------------------------------
    // Internal buses
    // --------------------------------------------------
    dispatch_if dp_bus ();
    issue_if    iss_bus ();
    cdb_if      cdb_bus ();

    // Old mapping handed back at retirement
    logic      free_valid;
    phys_reg_t free_prd;

    // --------------------------------------------------
    // Pipeline stages
    // --------------------------------------------------
    rename_unit u_rename (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_op_i    (inst_op_i),
        .inst_rd_i    (inst_rd_i),
        .inst_rs1_i   (inst_rs1_i),
        .inst_rs2_i   (inst_rs2_i),
        .inst_imm_i   (inst_imm_i),
        .free_valid_i (free_valid),
        .free_prd_i   (free_prd),
        .inst_ready_o (inst_ready_o),
        .dp           (dp_bus),
        .cdb          (cdb_bus)
    );

    reservation_station #(
        .RS_DEPTH (RS_DEPTH)
    ) u_rs (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .dp      (dp_bus),
        .cdb     (cdb_bus),
        .iss     (iss_bus)
    );

    execute_unit u_exec (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .iss     (iss_bus),
        .cdb     (cdb_bus)
    );

    reorder_buffer u_rob (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .free_valid_o (free_valid),
        .free_prd_o   (free_prd),
        .rt_valid_o   (rt_valid_o),
        .rt_rd_o      (rt_rd_o),
        .rt_data_o    (rt_data_o),
        .dp           (dp_bus),
        .cdb          (cdb_bus)
    );

endmodule

// File: verification/tb_ooo_core.sv
// Testbench for ooo_core with random program stimulus, golden model and retire checks
module tb_ooo_core;
    import ooo_pkg::*;

    localparam int RESET_CYCLES   = 16;
    localparam int N_PROLOGUE     = 16;
    localparam int N_RANDOM       = 300;
    // Generous per-instruction budget, dependent chains stall often
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 20 * (N_RANDOM + N_PROLOGUE);
    localparam int EXP_DEPTH      = 512;

    logic      clk_i = 1'b0;
    logic      rst_n_i;
    logic      inst_valid_i;
    op_e       inst_op_i;
    arch_reg_t inst_rd_i;
    arch_reg_t inst_rs1_i;
    arch_reg_t inst_rs2_i;
    data_t     inst_imm_i;
    logic      inst_ready_o;
    logic      rt_valid_o;
    arch_reg_t rt_rd_o;
    data_t     rt_data_o;

    // --------------------------------------------------
    // Golden model state
    // --------------------------------------------------
    data_t     arch_q   [ARCH_REGS];
    arch_reg_t exp_rd   [EXP_DEPTH];
    data_t     exp_data [EXP_DEPTH];
    int        wr_ptr;
    int        rd_ptr;
    int        cycle_count = 0;
    integer    seed        = 32'h2fe0_f731;
    logic      saw_stall;
    logic      rst_seen    = 1'b0;
    logic      rst_n_q     = 1'b0;

    ooo_core #(
        .RS_DEPTH (4)
    ) UUT (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_op_i    (inst_op_i),
        .inst_rd_i    (inst_rd_i),
        .inst_rs1_i   (inst_rs1_i),
        .inst_rs2_i   (inst_rs2_i),
        .inst_imm_i   (inst_imm_i),
        .inst_ready_o (inst_ready_o),
        .rt_valid_o   (rt_valid_o),
        .rt_rd_o      (rt_rd_o),
        .rt_data_o    (rt_data_o)
    );

    always #5 clk_i = ~clk_i;

    task automatic abort_run;
        $display(">>> FAIL");
        $fatal(1, "simulation stopped after an error");
    endtask

    task automatic report_mismatch(input string msg);
        $display("[FAIL] %0t %s", $time, msg);
        abort_run();
    endtask

    // Architectural result straight from the ISA definition
    function automatic data_t model_result(input op_e op, input data_t a, input data_t b,
                                           input data_t imm);
        case (op)
            OP_LI:   return imm;
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_XOR:  return a ^ b;
            default: return '0;
        endcase
    endfunction

    // Offer one instruction and hold it until accepted
    task automatic send(input op_e op, input arch_reg_t rd, input arch_reg_t rs1,
                        input arch_reg_t rs2, input data_t imm);
        inst_valid_i <= 1'b1;
        inst_op_i    <= op;
        inst_rd_i    <= rd;
        inst_rs1_i   <= rs1;
        inst_rs2_i   <= rs2;
        inst_imm_i   <= imm;
        @(posedge clk_i);
        while (!inst_ready_o) @(posedge clk_i);
    endtask

    task automatic idle(input int n);
        inst_valid_i <= 1'b0;
        repeat (n) @(posedge clk_i);
    endtask

    // --------------------------------------------------
    // Model update on acceptance, pop on retirement
    // --------------------------------------------------
    always @(posedge clk_i) begin
        rst_n_q <= rst_n_i;
        if (!rst_n_i) begin
            rst_seen  <= 1'b1;
            wr_ptr    <= 0;
            rd_ptr    <= 0;
            saw_stall <= 1'b0;
            for (int i = 0; i < ARCH_REGS; i++) begin
                arch_q[i] <= '0;
            end
        end else begin
            if (inst_valid_i && inst_ready_o) begin
                exp_rd[wr_ptr]    <= inst_rd_i;
                exp_data[wr_ptr]  <= model_result(inst_op_i, arch_q[inst_rs1_i],
                                                  arch_q[inst_rs2_i], inst_imm_i);
                arch_q[inst_rd_i] <= model_result(inst_op_i, arch_q[inst_rs1_i],
                                                  arch_q[inst_rs2_i], inst_imm_i);
                wr_ptr            <= wr_ptr + 1;
            end
            if (inst_valid_i && !inst_ready_o) begin
                saw_stall <= 1'b1;
            end
            if (rt_valid_o) begin
                rd_ptr <= rd_ptr + 1;
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, %0d of %0d instructions retired",
                     cycle_count, rd_ptr, wr_ptr);
            abort_run();
        end
    end

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------
    // Reset values, also one cycle past the release
    a_reset_state: assert property (@(posedge clk_i)
        (rst_seen && (!rst_n_i || !rst_n_q)) |-> (!rt_valid_o && inst_ready_o))
        else report_mismatch("retire valid or ready wrong around reset");

    a_retire_expected: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rt_valid_o |-> (rd_ptr < wr_ptr))
        else begin
            $display("Retirement seen with no accepted instruction outstanding");
            abort_run();
        end

    a_retire_rd: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (rt_valid_o && rd_ptr < wr_ptr) |-> (rt_rd_o == exp_rd[rd_ptr]))
        else report_mismatch($sformatf("retired rd %0d out of program order",
                                       $sampled(rt_rd_o)));

    a_retire_data: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (rt_valid_o && rd_ptr < wr_ptr) |-> (rt_data_o == exp_data[rd_ptr]))
        else report_mismatch($sformatf("retired data %h differs from golden model",
                                       $sampled(rt_data_o)));

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    initial begin
        arch_reg_t last_rd;
        arch_reg_t rs2;
        op_e       op;

        rst_n_i      <= 1'b0;
        inst_valid_i <= 1'b0;
        inst_op_i    <= OP_LI;
        inst_rd_i    <= '0;
        inst_rs1_i   <= '0;
        inst_rs2_i   <= '0;
        inst_imm_i   <= '0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_n_i <= 1'b1;

        // Prologue, LI to every register
        for (int r = 0; r < ARCH_REGS; r++) begin
            send(OP_LI, arch_reg_t'(r), '0, '0, data_t'(32'h0101_0101 * (r + 1)));
        end
        // Back-to-back dependents, exercises dispatch bypass
        send(OP_ADD, 3'd1, 3'd0, 3'd1, '0);
        send(OP_SUB, 3'd2, 3'd1, 3'd0, '0);
        send(OP_AND, 3'd3, 3'd2, 3'd1, '0);
        send(OP_XOR, 3'd4, 3'd3, 3'd2, '0);
        send(OP_ADD, 3'd4, 3'd4, 3'd4, '0);
        send(OP_SUB, 3'd5, 3'd4, 3'd3, '0);
        send(OP_XOR, 3'd6, 3'd5, 3'd5, '0);
        send(OP_AND, 3'd7, 3'd6, 3'd4, '0);
        last_rd = 3'd7;

        for (int n = 0; n < N_RANDOM; n++) begin
            if ($unsigned($random(seed)) % 8 == 0) begin
                idle(1 + $unsigned($random(seed)) % 3);
            end
            rs2 = arch_reg_t'($random(seed));
            if (n % 50 < 14) begin
                // Long chain through the last destination
                op = op_e'(3'd1 + 3'($unsigned($random(seed)) % 4));
                send(op, arch_reg_t'($random(seed)), last_rd, rs2, data_t'($random(seed)));
            end else begin
                op = op_e'(3'($unsigned($random(seed)) % 5));
                send(op, arch_reg_t'($random(seed)), arch_reg_t'($random(seed)), rs2,
                     data_t'($random(seed)));
            end
            last_rd = inst_rd_i;
        end

        // Drain, then a few quiet cycles for stray retirements
        idle(1);
        while (rd_ptr != wr_ptr) @(posedge clk_i);
        repeat (4) @(posedge clk_i);
        if (saw_stall) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display("Input never stalled, %0d accepted and %0d retired",
                     wr_ptr, rd_ptr);
            abort_run();
        end
    end

endmodule

// File: files.f
rtl/ooo_pkg.sv
rtl/ooo_if.sv
rtl/rename_unit.sv
rtl/reservation_station.sv
rtl/execute_unit.sv
rtl/reorder_buffer.sv
rtl/ooo_core.sv
verification/tb_ooo_core.sv

// File: Bender.yml
package:
  name: ooo_core

sources:
  - rtl/ooo_pkg.sv
  - rtl/ooo_if.sv
  - rtl/rename_unit.sv
  - rtl/reservation_station.sv
  - rtl/execute_unit.sv
  - rtl/reorder_buffer.sv
  - rtl/ooo_core.sv
  - target: test
    files:
      - verification/tb_ooo_core.sv
